//--- Makefile
# Verilator build and run of the data cache memory testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache_mem
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard bench/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx 'Result: PASSED' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_dcache_model.svh
// reference model of line contents, tags, signatures and reuse bits
`ifndef TB_DCACHE_MODEL_SVH
`define TB_DCACHE_MODEL_SVH

// expected outcome of one acked read
typedef struct packed {
  logic     hit;
  way_oh_t  oh;
  way_idx_t way;
  idx_t     idx;
  word_t    data;
  sig_t     sig;
} rd_exp_t;

tag_t  m_tag   [NumSets][NumWays];
logic  m_vld   [NumSets][NumWays];
word_t m_data  [NumSets][NumWays][NumBanks];
sig_t  m_sig   [NumSets][NumWays];
logic  m_reuse [NumSets][NumWays];

// set index above the low tag bits
function automatic sig_t make_sig(idx_t idx, tag_t tag);
  return {idx[SigIdxBits-1:0], tag[SigTagBits-1:0]};
endfunction

task automatic model_reset();
  for (int s = 0; s < NumSets; s++) begin
    for (int w = 0; w < NumWays; w++) begin
      m_tag[s][w]   = '0;
      m_vld[s][w]   = 1'b0;
      m_sig[s][w]   = '0;
      m_reuse[s][w] = 1'b0;
      for (int k = 0; k < NumBanks; k++) begin
        m_data[s][w][k] = '0;
      end
    end
  end
endtask

// every matching way shows in the one-hot vector, the lowest one supplies data
task automatic model_lookup(input idx_t idx, input off_t off, input tag_t tag,
                            output rd_exp_t e);
  e = '0;
  e.idx = idx;
  for (int w = 0; w < NumWays; w++) begin
    if (m_vld[idx][w] && m_tag[idx][w] == tag) begin
      e.oh[w] = 1'b1;
      if (!e.hit) begin
        e.hit  = 1'b1;
        e.way  = way_idx_t'(w);
        e.data = m_data[idx][w][off[BankBitPos]];
        e.sig  = m_sig[idx][w];
      end
    end
  end
endtask

task automatic model_evict(input idx_t idx, input way_oh_t way, output sig_t sig,
                           output logic reused);
  sig    = '0;
  reused = 1'b0;
  for (int w = 0; w < NumWays; w++) begin
    if (way[w]) begin
      sig    = m_sig[idx][w];
      reused = m_reuse[idx][w];
    end
  end
endtask

task automatic model_fill(input way_oh_t way, input idx_t idx, input tag_t tag,
                          input line_t line, input logic valid);
  for (int w = 0; w < NumWays; w++) begin
    if (way[w]) begin
      m_tag[idx][w]   = tag;
      m_vld[idx][w]   = valid;
      m_sig[idx][w]   = make_sig(idx, tag);
      m_reuse[idx][w] = 1'b0;
      for (int k = 0; k < NumBanks; k++) begin
        m_data[idx][w][k] = line[k*WordWidth +: WordWidth];
      end
    end
  end
endtask

task automatic model_write(input idx_t idx, input off_t off, input way_oh_t way,
                           input word_t data, input be_t be);
  for (int w = 0; w < NumWays; w++) begin
    for (int b = 0; b < BeWidth; b++) begin
      if (way[w] && be[b]) begin
        m_data[idx][w][off[BankBitPos]][8*b +: 8] = data[8*b +: 8];
      end
    end
  end
endtask

`endif

//--- bench/tb_dcache_mem.sv
// testbench top: clock, reset, LFSR stimulus, model checks and timeout
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_mem import cache_pkg::*; import pred_pkg::*; ();

  localparam int unsigned NumOps        = 3000;
  localparam int unsigned ResetCycles   = 5;
  localparam int unsigned TimeoutCycles = NumOps * 4 + ResetCycles;
  localparam logic [31:0] Seed          = 32'h37f6_cb63;
  // few distinct tags per set keep the hit rate high
  localparam tag_t        TagBase       = 20'h5_a3c0;

  logic    clk_i;
  logic    rst_ni;
  logic    rd_req_i;
  idx_t    rd_idx_i;
  off_t    rd_off_i;
  tag_t    rd_tag_i;
  logic    rd_ack_o;
  logic    rd_vld_o;
  logic    rd_hit_o;
  way_oh_t rd_hit_oh_o;
  word_t   rd_data_o;
  logic    wr_req_i;
  idx_t    wr_idx_i;
  off_t    wr_off_i;
  way_oh_t wr_way_i;
  word_t   wr_data_i;
  be_t     wr_be_i;
  logic    wr_ack_o;
  logic    fill_req_i;
  way_oh_t fill_way_i;
  idx_t    fill_idx_i;
  tag_t    fill_tag_i;
  line_t   fill_data_i;
  logic    fill_valid_i;
  sig_t    hit_sig_o;
  logic    evict_vld_o;
  sig_t    evict_sig_o;
  logic    evict_reused_o;

  `include "tb_dcache_model.svh"

  logic [31:0] lfsr_q;
  rd_exp_t     exp_q[$];
  logic        rd_acked;
  logic        wr_acked;
  int unsigned hit_cnt;
  int unsigned miss_cnt;
  int unsigned cycle_cnt = 0;

  dcache_mem_top i_dut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("timeout: test did not finish within %0d cycles", TimeoutCycles);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // random source and compare
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int unsigned n, output logic [63:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %0h, expected %0h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  // a request stays put until it is acked
  // gen low stops new requests
  task automatic drive_inputs(input logic gen);
    logic [63:0] r;
    logic [63:0] hi;
    if (!rd_req_i || rd_acked) begin
      draw(2, r);
      rd_req_i = gen && (r[1:0] != 2'b00);
      draw(3, r);
      rd_idx_i = idx_t'(r);
      draw(4, r);
      rd_off_i = off_t'(r);
      draw(2, r);
      rd_tag_i = TagBase + tag_t'(r[1:0]);
    end
    if (!wr_req_i || wr_acked) begin
      draw(1, r);
      wr_req_i = gen && r[0];
      draw(3, r);
      wr_idx_i = idx_t'(r);
      draw(4, r);
      wr_off_i = off_t'(r);
      draw(2, r);
      wr_way_i = way_oh_t'(1) << r[1:0];
      draw(64, r);
      wr_data_i = r;
      draw(8, r);
      wr_be_i = be_t'(r);
    end
    draw(3, r);
    fill_req_i = gen && (r[2:0] == 3'b000);
    if (fill_req_i) begin
      draw(2, r);
      fill_way_i = way_oh_t'(1) << r[1:0];
      draw(3, r);
      fill_idx_i = idx_t'(r);
      draw(2, r);
      fill_tag_i = TagBase + tag_t'(r[1:0]);
      draw(64, r);
      draw(64, hi);
      fill_data_i = {hi, r};
      // about one fill in eight invalidates its line
      draw(3, r);
      fill_valid_i = (r[2:0] != 3'b000);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks in the low clock phase and model update for the next edge
  //////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    rd_exp_t e;
    rd_exp_t e_new;
    logic    got_hit;
    logic    exp_rd_ack;
    logic    exp_wr_ack;
    logic    same_bank;
    sig_t    exp_sig;
    logic    exp_reused;
    got_hit = 1'b0;
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check("rd_vld_o", 64'(rd_vld_o), 64'h1);
      check("rd_hit_o", 64'(rd_hit_o), 64'(e.hit));
      check("rd_hit_oh_o", 64'(rd_hit_oh_o), 64'(e.oh));
      if (e.hit) begin
        check("rd_data_o", rd_data_o, e.data);
        check("hit_sig_o", 64'(hit_sig_o), 64'(e.sig));
        got_hit = 1'b1;
        hit_cnt++;
      end else begin
        check("hit_sig_o", 64'(hit_sig_o), 64'h0);
        miss_cnt++;
      end
    end else begin
      check("rd_vld_o", 64'(rd_vld_o), 64'h0);
    end

    same_bank  = (rd_off_i[BankBitPos] == wr_off_i[BankBitPos]);
    exp_rd_ack = rd_req_i & ~fill_req_i;
    exp_wr_ack = wr_req_i & ~fill_req_i & ~(exp_rd_ack & same_bank);
    check("rd_ack_o", 64'(rd_ack_o), 64'(exp_rd_ack));
    check("wr_ack_o", 64'(wr_ack_o), 64'(exp_wr_ack));
    check("evict_vld_o", 64'(evict_vld_o), 64'(fill_req_i));
    if (fill_req_i) begin
      model_evict(fill_idx_i, fill_way_i, exp_sig, exp_reused);
      check("evict_sig_o", 64'(evict_sig_o), 64'(exp_sig));
      check("evict_reused_o", 64'(evict_reused_o), 64'(exp_reused));
    end

    // lookup sees the arrays before this edge's writes
    if (exp_rd_ack) begin
      model_lookup(rd_idx_i, rd_off_i, rd_tag_i, e_new);
      exp_q.push_back(e_new);
    end
    if (fill_req_i) begin
      model_fill(fill_way_i, fill_idx_i, fill_tag_i, fill_data_i, fill_valid_i);
    end
    if (exp_wr_ack) begin
      model_write(wr_idx_i, wr_off_i, wr_way_i, wr_data_i, wr_be_i);
    end
    // a hit overrides the clear from a fill to the same line
    if (got_hit) begin
      m_reuse[e.idx][e.way] = 1'b1;
    end
    rd_acked = exp_rd_ack;
    wr_acked = exp_wr_ack;
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    rd_req_i     = 1'b0;
    rd_idx_i     = '0;
    rd_off_i     = '0;
    rd_tag_i     = '0;
    wr_req_i     = 1'b0;
    wr_idx_i     = '0;
    wr_off_i     = '0;
    wr_way_i     = '0;
    wr_data_i    = '0;
    wr_be_i      = '0;
    fill_req_i   = 1'b0;
    fill_way_i   = '0;
    fill_idx_i   = '0;
    fill_tag_i   = '0;
    fill_data_i  = '0;
    fill_valid_i = 1'b0;
    lfsr_q       = Seed;
    rd_acked     = 1'b0;
    wr_acked     = 1'b0;
    hit_cnt      = 0;
    miss_cnt     = 0;
    model_reset();

    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int unsigned i = 0; i < NumOps; i++) begin
      drive_inputs(1'b1);
      #1;
      check_cycle();
      @(negedge clk_i);
    end
    // let held requests and the last result drain
    repeat (4) begin
      drive_inputs(1'b0);
      #1;
      check_cycle();
      @(negedge clk_i);
    end

    if (hit_cnt == 0 || miss_cnt == 0) begin
      $display("lookups not covered: %0d hits and %0d misses", hit_cnt, miss_cnt);
      $display("Result: FAILED");
      $fatal(1, "hit or miss case never reached");
    end else begin
      $display("checked %0d hits and %0d misses", hit_cnt, miss_cnt);
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src/array_port_if.sv
// tag and data bank command bundle from the bank scheduler to the arrays
`timescale 1ns/100ps
`default_nettype none

interface array_port_if import cache_pkg::*; ();

  // clocking forwarded by the scheduler
  logic clk;
  logic rst_n;

  // tag and valid arrays with one request per way
  way_oh_t tag_req;
  logic    tag_we;
  idx_t    tag_idx;
  tag_t    tag_wdata;
  logic    tag_wvalid;

  // each data bank holds one word of every way
  logic  [NumBanks-1:0]              bank_req;
  logic  [NumBanks-1:0]              bank_we;
  idx_t  [NumBanks-1:0]              bank_idx;
  be_t   [NumBanks-1:0][NumWays-1:0] bank_be;
  word_t [NumBanks-1:0][NumWays-1:0] bank_wdata;

  modport sched (
    output clk, rst_n, tag_req, tag_we, tag_idx, tag_wdata, tag_wvalid,
    output bank_req, bank_we, bank_idx, bank_be, bank_wdata
  );

  modport mem (
    input clk, rst_n, tag_req, tag_we, tag_idx, tag_wdata, tag_wvalid,
    input bank_req, bank_we, bank_idx, bank_be, bank_wdata
  );

endinterface

`default_nettype wire

//--- src/cache_pkg.sv
// cache geometry constants, vector types and the one-hot way encoder
`default_nettype none

package cache_pkg;

  // geometry of the L1 data cache
  localparam int unsigned NumWays    = 4;
  localparam int unsigned NumSets    = 64;
  localparam int unsigned NumBanks   = 2;
  localparam int unsigned IdxWidth   = 6;
  localparam int unsigned TagWidth   = 20;
  localparam int unsigned OffWidth   = 4;
  localparam int unsigned WordWidth  = 64;
  // offset bit 3 picks the 8-byte bank inside a 16-byte line
  localparam int unsigned BankBitPos = 3;

  // derived widths
  localparam int unsigned WayIdxWidth  = $clog2(NumWays);
  localparam int unsigned BankSelWidth = $clog2(NumBanks);
  localparam int unsigned BeWidth      = WordWidth / 8;
  localparam int unsigned LineWidth    = NumBanks * WordWidth;

  typedef logic [IdxWidth-1:0]     idx_t;
  typedef logic [TagWidth-1:0]     tag_t;
  typedef logic [OffWidth-1:0]     off_t;
  typedef logic [WordWidth-1:0]    word_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [LineWidth-1:0]    line_t;
  typedef logic [NumWays-1:0]      way_oh_t;
  typedef logic [WayIdxWidth-1:0]  way_idx_t;
  typedef logic [BankSelWidth-1:0] bank_sel_t;

  // lowest set bit wins, zero maps to way 0
  function automatic way_idx_t oh_to_idx(way_oh_t oh);
    way_idx_t idx;
    idx = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (oh[i]) begin
        idx = way_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- src/dcache_arrays.sv
// tag, valid and data bank memories with registered read data
`timescale 1ns/100ps
`default_nettype none

module dcache_arrays import cache_pkg::*; (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  array_port_if.mem                              ap,
  output      tag_t  [NumWays-1:0]               tag_rdata_o,
  output      way_oh_t                           vld_rdata_o,
  output      word_t [NumBanks-1:0][NumWays-1:0] bank_rdata_o
);

  // one tag memory per way
  tag_t tag_mem [NumWays][NumSets];
  // valid bits per way and set
  logic [NumWays-1:0][NumSets-1:0] vld_q;
  // each bank keeps the matching word of all four ways
  word_t bank_mem [NumBanks][NumSets][NumWays];

  //////////////////////////////////////////////////////////////////////
  // tag and valid arrays
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (ap.tag_req[w]) begin
        tag_rdata_o[w] <= tag_mem[w][ap.tag_idx];
        if (ap.tag_we) begin
          tag_mem[w][ap.tag_idx] <= ap.tag_wdata;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q       <= '0;
      vld_rdata_o <= '0;
    end else begin
      for (int w = 0; w < NumWays; w++) begin
        if (ap.tag_req[w]) begin
          vld_rdata_o[w] <= vld_q[w][ap.tag_idx];
          if (ap.tag_we) begin
            vld_q[w][ap.tag_idx] <= ap.tag_wvalid;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data banks
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NumBanks; k++) begin
      if (ap.bank_req[k]) begin
        for (int j = 0; j < NumWays; j++) begin
          bank_rdata_o[k][j] <= bank_mem[k][ap.bank_idx[k]][j];
          // byte lanes merge only where enabled
          for (int b = 0; b < BeWidth; b++) begin
            if (ap.bank_we[k] && ap.bank_be[k][j][b]) begin
              bank_mem[k][ap.bank_idx[k]][j][8*b +: 8] <= ap.bank_wdata[k][j][8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dcache_bank_sched.sv
// bank scheduler: fill, read and word write selection with array commands
`timescale 1ns/100ps
`default_nettype none

module dcache_bank_sched import cache_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // read request
  input  wire logic        rd_req_i,
  input  wire idx_t        rd_idx_i,
  input  wire off_t        rd_off_i,
  input  wire tag_t        rd_tag_i,
  output      logic        rd_ack_o,
  // single word write
  input  wire logic        wr_req_i,
  input  wire idx_t        wr_idx_i,
  input  wire off_t        wr_off_i,
  input  wire way_oh_t     wr_way_i,
  input  wire word_t       wr_data_i,
  input  wire be_t         wr_be_i,
  output      logic        wr_ack_o,
  // line fill
  input  wire logic        fill_req_i,
  input  wire way_oh_t     fill_way_i,
  input  wire idx_t        fill_idx_i,
  input  wire tag_t        fill_tag_i,
  input  wire line_t       fill_data_i,
  input  wire logic        fill_valid_i,
  array_port_if.sched      ap,
  lookup_if.sched          lk
);

  bank_sel_t rd_bank;
  bank_sel_t wr_bank;

  assign rd_bank = rd_off_i[BankBitPos];
  assign wr_bank = wr_off_i[BankBitPos];

  // fills always win, a write only loses its bank to a read
  assign rd_ack_o = rd_req_i & ~fill_req_i;
  assign wr_ack_o = wr_req_i & ~fill_req_i & ~(rd_ack_o & (rd_bank == wr_bank));

  assign ap.clk   = clk_i;
  assign ap.rst_n = rst_ni;

  assign lk.vld = rd_ack_o;
  assign lk.idx = rd_idx_i;
  assign lk.off = rd_off_i;
  assign lk.tag = rd_tag_i;

  //////////////////////////////////////////////////////////////////////
  // array commands
  //////////////////////////////////////////////////////////////////////

  assign ap.tag_we     = fill_req_i;
  assign ap.tag_idx    = fill_req_i ? fill_idx_i : rd_idx_i;
  assign ap.tag_wdata  = fill_tag_i;
  assign ap.tag_wvalid = fill_valid_i;
  assign ap.tag_req    = fill_req_i ? fill_way_i : {NumWays{rd_ack_o}};

  always_comb begin
    ap.bank_req = '0;
    ap.bank_we  = '0;
    for (int k = 0; k < NumBanks; k++) begin
      ap.bank_idx[k] = fill_req_i ? fill_idx_i : wr_idx_i;
      for (int j = 0; j < NumWays; j++) begin
        ap.bank_be[k][j]    = '0;
        ap.bank_wdata[k][j] = fill_req_i ? fill_data_i[k*WordWidth +: WordWidth] : wr_data_i;
      end
    end

    if (fill_req_i) begin
      // whole line into the chosen way
      ap.bank_req = '1;
      ap.bank_we  = '1;
      for (int k = 0; k < NumBanks; k++) begin
        for (int j = 0; j < NumWays; j++) begin
          ap.bank_be[k][j] = {BeWidth{fill_way_i[j]}};
        end
      end
    end else begin
      if (rd_ack_o) begin
        ap.bank_req[rd_bank] = 1'b1;
        ap.bank_idx[rd_bank] = rd_idx_i;
      end
      if (wr_ack_o) begin
        ap.bank_req[wr_bank] = 1'b1;
        ap.bank_we[wr_bank]  = 1'b1;
        for (int j = 0; j < NumWays; j++) begin
          ap.bank_be[wr_bank][j] = wr_way_i[j] ? wr_be_i : '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dcache_hit_sel.sv
// hit selector: registered lookup, tag compare, way encode and data mux
`timescale 1ns/100ps
`default_nettype none

module dcache_hit_sel import cache_pkg::*; (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  lookup_if.sel                                  lk,
  input  wire tag_t  [NumWays-1:0]               tag_rdata_i,
  input  wire way_oh_t                           vld_rdata_i,
  input  wire word_t [NumBanks-1:0][NumWays-1:0] bank_rdata_i,
  output      logic                              rd_vld_o,
  output      logic                              rd_hit_o,
  output      way_oh_t                           rd_hit_oh_o,
  output      way_idx_t                          rd_hit_way_o,
  output      idx_t                              rd_hit_idx_o,
  output      word_t                             rd_data_o
);

  logic      lk_vld_q;
  idx_t      lk_idx_q;
  bank_sel_t lk_bank_q;
  tag_t      lk_tag_q;
  way_oh_t   hit_oh;
  way_idx_t  hit_way;

  //////////////////////////////////////////////////////////////////////
  // lookup register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lk_vld_q <= 1'b0;
    end else begin
      lk_vld_q <= lk.vld;
    end
  end

  // address and tag of the accepted lookup
  always_ff @(posedge clk_i) begin
    if (lk.vld) begin
      lk_idx_q  <= lk.idx;
      lk_bank_q <= lk.off[BankBitPos];
      lk_tag_q  <= lk.tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tag compare and readout
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      hit_oh[w] = lk_vld_q & vld_rdata_i[w] & (tag_rdata_i[w] == lk_tag_q);
    end
  end

  // the lowest hitting way supplies the data
  assign hit_way = oh_to_idx(hit_oh);

  assign rd_vld_o     = lk_vld_q;
  assign rd_hit_o     = |hit_oh;
  assign rd_hit_oh_o  = hit_oh;
  assign rd_hit_way_o = hit_way;
  assign rd_hit_idx_o = lk_idx_q;
  // word of the hitting way from the bank that was read
  assign rd_data_o    = bank_rdata_i[lk_bank_q][hit_way];

endmodule

`default_nettype wire

//--- src/dcache_mem_top.sv
// L1 data cache memory core top level with plain request and result ports
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_top import cache_pkg::*; import pred_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  // read
  input  wire logic    rd_req_i,
  input  wire idx_t    rd_idx_i,
  input  wire off_t    rd_off_i,
  input  wire tag_t    rd_tag_i,
  output      logic    rd_ack_o,
  output      logic    rd_vld_o,
  output      logic    rd_hit_o,
  output      way_oh_t rd_hit_oh_o,
  output      word_t   rd_data_o,
  // word write
  input  wire logic    wr_req_i,
  input  wire idx_t    wr_idx_i,
  input  wire off_t    wr_off_i,
  input  wire way_oh_t wr_way_i,
  input  wire word_t   wr_data_i,
  input  wire be_t     wr_be_i,
  output      logic    wr_ack_o,
  // fill
  input  wire logic    fill_req_i,
  input  wire way_oh_t fill_way_i,
  input  wire idx_t    fill_idx_i,
  input  wire tag_t    fill_tag_i,
  input  wire line_t   fill_data_i,
  input  wire logic    fill_valid_i,
  // predictor
  output      sig_t    hit_sig_o,
  output      logic    evict_vld_o,
  output      sig_t    evict_sig_o,
  output      logic    evict_reused_o
);

  tag_t  [NumWays-1:0]               tag_rdata;
  way_oh_t                           vld_rdata;
  word_t [NumBanks-1:0][NumWays-1:0] bank_rdata;
  way_idx_t                          hit_way;
  idx_t                              hit_idx;

  array_port_if i_ap ();
  lookup_if     i_lk ();

  dcache_bank_sched i_sched (
    .clk_i, .rst_ni,
    .rd_req_i, .rd_idx_i, .rd_off_i, .rd_tag_i, .rd_ack_o,
    .wr_req_i, .wr_idx_i, .wr_off_i, .wr_way_i, .wr_data_i, .wr_be_i, .wr_ack_o,
    .fill_req_i, .fill_way_i, .fill_idx_i, .fill_tag_i, .fill_data_i, .fill_valid_i,
    .ap (i_ap.sched),
    .lk (i_lk.sched)
  );

  dcache_arrays i_arrays (
    .clk_i, .rst_ni,
    .ap           (i_ap.mem),
    .tag_rdata_o  (tag_rdata),
    .vld_rdata_o  (vld_rdata),
    .bank_rdata_o (bank_rdata)
  );

  dcache_hit_sel i_hit_sel (
    .clk_i, .rst_ni,
    .lk           (i_lk.sel),
    .tag_rdata_i  (tag_rdata),
    .vld_rdata_i  (vld_rdata),
    .bank_rdata_i (bank_rdata),
    .rd_vld_o, .rd_hit_o, .rd_hit_oh_o,
    .rd_hit_way_o (hit_way),
    .rd_hit_idx_o (hit_idx),
    .rd_data_o
  );

  dcache_reuse_track i_reuse (
    .clk_i, .rst_ni,
    .rd_hit_i     (rd_hit_o),
    .rd_hit_way_i (hit_way),
    .rd_hit_idx_i (hit_idx),
    .fill_req_i, .fill_way_i, .fill_idx_i, .fill_tag_i,
    .hit_sig_o, .evict_vld_o, .evict_sig_o, .evict_reused_o
  );

endmodule

`default_nettype wire

//--- src/dcache_reuse_track.sv
// reuse tracker: per-line signature and reuse bit with hit and evict reports
`timescale 1ns/100ps
`default_nettype none

module dcache_reuse_track import cache_pkg::*; import pred_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // hit from the selector
  input  wire logic     rd_hit_i,
  input  wire way_idx_t rd_hit_way_i,
  input  wire idx_t     rd_hit_idx_i,
  // fill command
  input  wire logic     fill_req_i,
  input  wire way_oh_t  fill_way_i,
  input  wire idx_t     fill_idx_i,
  input  wire tag_t     fill_tag_i,
  // predictor reports
  output      sig_t     hit_sig_o,
  output      logic     evict_vld_o,
  output      sig_t     evict_sig_o,
  output      logic     evict_reused_o
);

  sig_t [NumSets-1:0][NumWays-1:0] sig_q;
  logic [NumSets-1:0][NumWays-1:0] reuse_q;
  way_idx_t                        fill_way;
  sig_t                            fill_sig;

  assign fill_way = oh_to_idx(fill_way_i);
  assign fill_sig = {fill_idx_i[SigIdxBits-1:0], fill_tag_i[SigTagBits-1:0]};

  //////////////////////////////////////////////////////////////////////
  // reports from the state before this edge
  //////////////////////////////////////////////////////////////////////

  assign hit_sig_o      = rd_hit_i ? sig_q[rd_hit_idx_i][rd_hit_way_i] : '0;
  assign evict_vld_o    = fill_req_i;
  assign evict_sig_o    = fill_req_i ? sig_q[fill_idx_i][fill_way] : '0;
  assign evict_reused_o = fill_req_i & reuse_q[fill_idx_i][fill_way];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sig_q   <= '0;
      reuse_q <= '0;
    end else begin
      if (fill_req_i) begin
        sig_q[fill_idx_i][fill_way]   <= fill_sig;
        reuse_q[fill_idx_i][fill_way] <= 1'b0;
      end
      // hit comes last so it overrides a fill to the same line
      if (rd_hit_i) begin
        reuse_q[rd_hit_idx_i][rd_hit_way_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/lookup_if.sv
// accepted read lookup passed from the bank scheduler to the hit selector
`timescale 1ns/100ps
`default_nettype none

interface lookup_if import cache_pkg::*; ();

  // vld is high in the cycle a read is acked
  logic vld;
  idx_t idx;
  off_t off;
  tag_t tag;

  modport sched (
    output vld, idx, off, tag
  );

  modport sel (
    input vld, idx, off, tag
  );

endinterface

`default_nettype wire

//--- src/pred_pkg.sv
// reuse predictor constants and the line signature type
`default_nettype none

package pred_pkg;

  // a signature keeps the set index above the low tag bits
  localparam int unsigned SigIdxBits = 6;
  localparam int unsigned SigTagBits = 8;
  localparam int unsigned SigWidth   = SigIdxBits + SigTagBits;

  //////////////////////////////////////////////////////////////////////
  // signature layout
  //   [13:8] set index of the fill
  //   [7:0]  low bits of the fill tag
  //////////////////////////////////////////////////////////////////////

  typedef logic [SigWidth-1:0] sig_t;

endpackage

`default_nettype wire

//--- verilog.f
+incdir+bench
src/cache_pkg.sv
src/pred_pkg.sv
src/array_port_if.sv
src/lookup_if.sv
src/dcache_bank_sched.sv
src/dcache_arrays.sv
src/dcache_hit_sel.sv
src/dcache_reuse_track.sv
src/dcache_mem_top.sv
bench/tb_dcache_mem.sv
